//--- logic/emesh_pkg.sv
package emesh_pkg;

   //##########################################################################
   // Packet geometry
   //##########################################################################

   localparam int unsigned pkt_aw = 32;                       // Address width
   localparam int unsigned pkt_w  = 2*pkt_aw + 40;            // Full packet, 104 bits
   localparam int unsigned ctrl_w = 8;                        // Control byte on top
   localparam int unsigned data_w = 32;                       // One data word
   localparam int unsigned ret_w  = pkt_w - ctrl_w - pkt_aw - data_w - 1; // 31 bits

   //##########################################################################
   // Request views, same 104 bits decoded two ways
   //##########################################################################

   typedef struct packed {
      logic [ctrl_w-1:0] ctrl;                                // Control byte
      logic [pkt_aw-1:0] dst_addr;                            // Register address
      logic [data_w-1:0] data;                                // Write data
      logic [ret_w-1:0]  unused;                              // Don't care on writes
      logic              write;                               // Bit 0, set for write
   } emesh_wr_s;

   typedef struct packed {
      logic [ctrl_w-1:0] ctrl;                                // Control byte
      logic [pkt_aw-1:0] dst_addr;                            // Register address
      logic [data_w-1:0] unused;                              // Don't care on reads
      logic [ret_w-1:0]  ret_addr;                            // Where read data goes
      logic              write;                               // Bit 0, clear for read
   } emesh_rd_s;

   typedef union packed {
      emesh_wr_s wr;                                          // Write decode
      emesh_rd_s rd;                                          // Read decode
   } emesh_req_u;

   // A response travels as an ordinary write packet to the return address
   typedef emesh_wr_s emesh_rsp_s;

endpackage

//--- logic/axi_pkg.sv
package axi_pkg;

   //##########################################################################
   // Channel widths and register map
   //##########################################################################

   localparam int unsigned axi_aw = 32;                       // AXI address width
   localparam int unsigned axi_dw = 32;                       // AXI data width
   localparam int unsigned reg_ow = 4;                        // Decoded offset bits

   localparam logic [reg_ow-1:0] reg_op_a   = 4'h0;           // Operand A, rw
   localparam logic [reg_ow-1:0] reg_op_b   = 4'h4;           // Operand B, rw
   localparam logic [reg_ow-1:0] reg_result = 4'h8;           // A + B, ro
   localparam logic [reg_ow-1:0] reg_ident  = 4'hC;           // Identity, ro

   localparam logic [axi_dw-1:0] accel_ident = 32'h0000_0810; // Block id

   //##########################################################################
   // Master to slave channels
   //##########################################################################

   typedef struct packed {
      logic [axi_aw-1:0] addr;                                // Byte address
      logic              valid;                               // Held until ready
   } axi_addr_s;

   typedef struct packed {
      logic [axi_dw-1:0] data;                                // Single beat word
      logic              valid;                               // Held until ready
   } axi_data_s;

   typedef axi_addr_s axi_aw_s;                               // Write address
   typedef axi_addr_s axi_ar_s;                               // Read address
   typedef axi_data_s axi_w_s;                                // Write data, full strobe

   //##########################################################################
   // Slave to master channels
   //##########################################################################

   typedef axi_data_s axi_r_s;                                // Read data, always OKAY

   typedef struct packed {
      logic awready;                                          // Write addr taken
      logic wready;                                           // Write data taken
      logic arready;                                          // Read addr taken
      logic bvalid;                                           // Write done, one cycle
   } axi_s2m_s;

endpackage

//--- logic/emesh_axi_master.sv
`timescale 1ns/100ps

module emesh_axi_master (
   input  logic                  clk,
   input  logic                  arst_n,
   // Request packets in
   input  logic                  access_in,
   input  emesh_pkg::emesh_req_u packet_in,
   output logic                  wait_out,
   // Read responses out
   output logic                  access_out,
   output emesh_pkg::emesh_rsp_s packet_out,
   input  logic                  wait_in,
   // AXI master side
   output axi_pkg::axi_aw_s      aw,
   output axi_pkg::axi_w_s       w,
   output axi_pkg::axi_ar_s      ar,
   input  axi_pkg::axi_s2m_s     s2m,
   input  axi_pkg::axi_r_s       r,
   output logic                  bready,
   output logic                  rready
);

   import emesh_pkg::*;
   import axi_pkg::*;

   //##########################################################################
   // Declarations
   //##########################################################################

   typedef enum logic [1:0] {
      st_idle,                                                // Free for a request
      st_write,                                               // aw/w out, waiting for b
      st_read,                                                // ar out, waiting for r
      st_resp                                                 // Response held on output
   } state_e;

   state_e            state;
   logic              wr_valid;                               // Drives aw and w valid
   logic              ar_valid;
   logic              rsp_valid;                              // Response register full
   logic [axi_aw-1:0] req_addr;                               // Same for aw and ar
   logic [axi_dw-1:0] wr_data;
   logic [ret_w-1:0]  ret_addr;                               // Read requester
   logic [axi_dw-1:0] rsp_data;
   logic              req_take;
   logic              wr_hs;
   logic              ar_hs;
   logic              r_hs;

   //##########################################################################
   // Handshakes
   //##########################################################################

   assign wait_out = (state != st_idle);                      // Busy until fully done
   assign req_take = access_in & ~wait_out;                   // Packet transfer edge

   assign wr_hs = wr_valid & s2m.awready & s2m.wready;        // Slave takes both at once
   assign ar_hs = ar_valid & s2m.arready;
   assign r_hs  = r.valid & rready;

   assign bready = 1'b1;                                      // Always sink b
   assign rready = ~rsp_valid;                                // Room in response reg

   //##########################################################################
   // Control FSM
   //##########################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= st_idle;
         wr_valid  <= 1'b0;
         ar_valid  <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (req_take) begin
                  if (packet_in.wr.write) begin               // Split on bit 0
                     state    <= st_write;
                     wr_valid <= 1'b1;                        // aw and w together
                  end else begin
                     state    <= st_read;
                     ar_valid <= 1'b1;
                  end
               end
            end
            st_write: begin
               if (wr_hs) begin
                  wr_valid <= 1'b0;                           // Drop only after transfer
               end
               if (s2m.bvalid && bready) begin
                  state <= st_idle;                           // Write complete
               end
            end
            st_read: begin
               if (ar_hs) begin
                  ar_valid <= 1'b0;
               end
               if (r_hs) begin
                  rsp_valid <= 1'b1;                          // access_out next cycle
                  state     <= st_resp;
               end
            end
            st_resp: begin
               if (!wait_in) begin                            // Receiver took it
                  rsp_valid <= 1'b0;
                  state     <= st_idle;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   //##########################################################################
   // Payload registers
   //##########################################################################

   always_ff @(posedge clk) begin
      if (req_take) begin
         req_addr <= packet_in.wr.dst_addr;                   // Both views agree here
         wr_data  <= packet_in.wr.data;                       // Write view
         ret_addr <= packet_in.rd.ret_addr;                   // Read view
      end
      if (r_hs) begin
         rsp_data <= r.data;                                  // Holds under wait_in
      end
   end

   //##########################################################################
   // Outputs
   //##########################################################################

   assign aw = '{addr: req_addr, valid: wr_valid};
   assign w  = '{data: wr_data,  valid: wr_valid};
   assign ar = '{addr: req_addr, valid: ar_valid};

   assign access_out = rsp_valid;

   // Response goes back as a write to the requester
   assign packet_out = '{ctrl:     '0,
                         dst_addr: pkt_aw'(ret_addr),         // Zero extended
                         data:     rsp_data,
                         unused:   '0,
                         write:    1'b1};

endmodule

//--- logic/accel_regs.sv
`timescale 1ns/100ps

module accel_regs (
   input  logic              clk,
   input  logic              arst_n,
   // AXI slave side
   input  axi_pkg::axi_aw_s  aw,
   input  axi_pkg::axi_w_s   w,
   input  axi_pkg::axi_ar_s  ar,
   output axi_pkg::axi_s2m_s s2m,
   output axi_pkg::axi_r_s   r,
   input  logic              bready,
   input  logic              rready
);

   import axi_pkg::*;

   //##########################################################################
   // Declarations
   //##########################################################################

   logic [axi_dw-1:0] op_a;                                   // Operand A
   logic [axi_dw-1:0] op_b;                                   // Operand B
   logic [axi_dw-1:0] sum;                                    // Wraps at 2^32
   logic [axi_dw-1:0] rd_mux;
   logic [axi_dw-1:0] rdata;                                  // Pending read datum
   logic [reg_ow-1:0] wr_off;
   logic [reg_ow-1:0] rd_off;
   logic              b_pend;                                 // Write response out
   logic              r_pend;                                 // Read data out
   logic              wr_hs;
   logic              ar_hs;

   assign wr_off = aw.addr[reg_ow-1:0];                       // Upper bits ignored
   assign rd_off = ar.addr[reg_ow-1:0];

   // Accept address and data together, one response at a time
   assign wr_hs = aw.valid & w.valid & ~b_pend;
   assign ar_hs = ar.valid & ~r_pend;

   //##########################################################################
   // Register file
   //##########################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         op_a <= '0;
         op_b <= '0;
      end else if (wr_hs) begin
         case (wr_off)
            reg_op_a: op_a <= w.data;
            reg_op_b: op_b <= w.data;
            default: ;                                        // Completed, no effect
         endcase
      end
   end

   assign sum = op_a + op_b;                                  // Carry dropped

   always_comb begin
      case (rd_off)
         reg_op_a:   rd_mux = op_a;
         reg_op_b:   rd_mux = op_b;
         reg_result: rd_mux = sum;
         reg_ident:  rd_mux = accel_ident;
         default:    rd_mux = '0;                             // Unmapped reads zero
      endcase
   end

   //##########################################################################
   // Response channels
   //##########################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         b_pend <= 1'b0;
         r_pend <= 1'b0;
      end else begin
         if (wr_hs) begin
            b_pend <= 1'b1;                                   // bvalid next cycle
         end else if (bready) begin
            b_pend <= 1'b0;
         end
         if (ar_hs) begin
            r_pend <= 1'b1;                                   // rvalid next cycle
         end else if (rready) begin
            r_pend <= 1'b0;                                   // Held until taken
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         rdata <= rd_mux;                                     // Snapshot at ar transfer
      end
   end

   assign s2m = '{awready: wr_hs,
                  wready:  wr_hs,
                  arready: ~r_pend,
                  bvalid:  b_pend};

   assign r = '{data: rdata, valid: r_pend};

endmodule

//--- logic/accel_dut.sv
`timescale 1ns/100ps

module accel_dut (
   input  logic                  clk,
   input  logic                  arst_n,
   // Request port
   input  logic                  access_in,
   input  emesh_pkg::emesh_req_u packet_in,
   output logic                  wait_out,
   // Response port
   output logic                  access_out,
   output emesh_pkg::emesh_rsp_s packet_out,
   input  logic                  wait_in
);

   import axi_pkg::*;

   //##########################################################################
   // Internal AXI-lite link
   //##########################################################################

   axi_aw_s  aw;                                              // Bridge to accel
   axi_w_s   w;
   axi_ar_s  ar;
   axi_s2m_s s2m;                                             // Accel readies and bvalid
   axi_r_s   r;
   logic     bready;
   logic     rready;

   emesh_axi_master bridge_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .aw         (aw),
      .w          (w),
      .ar         (ar),
      .s2m        (s2m),
      .r          (r),
      .bready     (bready),
      .rready     (rready)
   );

   accel_regs accel_i (
      .clk    (clk),
      .arst_n (arst_n),
      .aw     (aw),
      .w      (w),
      .ar     (ar),
      .s2m    (s2m),
      .r      (r),
      .bready (bready),
      .rready (rready)
   );

endmodule

//--- sim/accel_dut_props.sv
`timescale 1ns/100ps

module accel_dut_props (
   input logic                  clk,
   input logic                  arst_n,
   input logic                  access_in,
   input logic                  wait_out,
   input logic                  access_out,
   input emesh_pkg::emesh_rsp_s packet_out,
   input logic                  wait_in,
   input axi_pkg::axi_aw_s      aw,
   input axi_pkg::axi_w_s       w,
   input axi_pkg::axi_ar_s      ar,
   input axi_pkg::axi_s2m_s     s2m,
   input axi_pkg::axi_r_s       r,
   input logic                  rready
);

   logic rsp_bad  = 1'b0;                                    // Sticky per property
   logic take_bad = 1'b0;
   logic wr_bad   = 1'b0;
   logic ar_bad   = 1'b0;
   logic r_bad    = 1'b0;
   logic prop_fail;

   assign prop_fail = rsp_bad | take_bad | wr_bad | ar_bad | r_bad;

   //##########################################################################
   // Packet ports
   //##########################################################################

   rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
      access_out && wait_in |=> access_out && $stable(packet_out))
   else begin
      $error("response moved while wait_in was high");
      rsp_bad = 1'b1;
   end

   // New AXI request only after a packet transfer edge
   req_take: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(aw.valid) || $rose(ar.valid) |-> $past(access_in && !wait_out))
   else begin
      $error("request taken while wait_out was high");
      take_bad = 1'b1;
   end

   //##########################################################################
   // AXI valid holding
   //##########################################################################

   // Every valid drop must follow a completed handshake
   wr_hold: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(aw.valid) || $fell(w.valid) |->
         $past(aw.valid && s2m.awready && w.valid && s2m.wready))
   else begin
      $error("aw or w valid dropped before its handshake");
      wr_bad = 1'b1;
   end

   ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(ar.valid) |-> $past(s2m.arready))
   else begin
      $error("ar valid dropped before its handshake");
      ar_bad = 1'b1;
   end

   r_hold: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(r.valid) |-> $past(rready))
   else begin
      $error("r valid dropped before its handshake");
      r_bad = 1'b1;
   end

endmodule

bind accel_dut accel_dut_props props_i (.*);

//--- sim/accel_dut_tb.sv
`timescale 1ns/100ps

module accel_dut_tb;

   import emesh_pkg::*;
   import axi_pkg::*;

   localparam int unsigned n_rows     = 16;
   localparam int unsigned clk_period = 40;

   typedef struct packed {
      logic        wr;                                       // 1 write, 0 read
      logic [31:0] addr;                                     // Full request address
      logic [31:0] data;                                     // Write data
      logic [31:0] exp;                                      // Expected read value
   } row_s;

   logic        clk;
   logic        arst_n;
   logic        access_in;
   emesh_req_u  packet_in;
   logic        wait_out;
   logic        access_out;
   emesh_rsp_s  packet_out;
   logic        wait_in;

   row_s        rows [n_rows];
   int unsigned n_checks;
   int unsigned n_errors;

   always #(clk_period/2) clk = ~clk;

   accel_dut accel_dut_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   //##########################################################################
   // Helpers
   //##########################################################################

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      n_checks++;
      assert (got === exp) else begin
         $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
         n_errors++;
      end
   endtask

   task automatic build_table();
      logic [31:0] a0;
      logic [31:0] b0;
      logic [31:0] a1;
      logic [31:0] b1;
      a0 = $urandom;
      b0 = $urandom;
      a1 = $urandom | 32'h8000_0000;                         // Top bits set, sum must wrap
      b1 = $urandom | 32'h8000_0000;
      rows[0]  = '{1'b1, 32'(reg_op_a), a0, 32'h0};
      rows[1]  = '{1'b1, 32'(reg_op_b), b0, 32'h0};
      rows[2]  = '{1'b0, 32'(reg_result), 32'h0, a0 + b0};  // Modulo 2^32
      rows[3]  = '{1'b0, 32'(reg_op_a), 32'h0, a0};
      rows[4]  = '{1'b0, 32'(reg_op_b), 32'h0, b0};
      rows[5]  = '{1'b1, 32'(reg_result), $urandom, 32'h0}; // Read-only, ignored
      rows[6]  = '{1'b1, 32'(reg_ident), $urandom, 32'h0};
      rows[7]  = '{1'b0, 32'(reg_op_a), 32'h0, a0};
      rows[8]  = '{1'b0, 32'(reg_result), 32'h0, a0 + b0};
      rows[9]  = '{1'b0, 32'(reg_ident), 32'h0, 32'h0000_0810};
      rows[10] = '{1'b0, 32'h0000_0002, 32'h0, 32'h0};      // Unmapped offset
      rows[11] = '{1'b0, 32'hFFFF_FF14, 32'h0, b0};         // Only low nibble decoded
      rows[12] = '{1'b1, 32'(reg_op_a), a1, 32'h0};
      rows[13] = '{1'b1, 32'(reg_op_b), b1, 32'h0};
      rows[14] = '{1'b0, 32'(reg_result), 32'h0, a1 + b1};
      rows[15] = '{1'b0, 32'(reg_op_a), 32'h0, a1};
   endtask

   task automatic send_request(input row_s row, input logic [30:0] ret);
      emesh_req_u req;
      while (wait_out) @(negedge clk);                       // Bridge still busy
      if (row.wr) begin
         req.wr = '{8'($urandom), row.addr, row.data, 31'($urandom), 1'b1};
      end else begin
         req.rd = '{8'($urandom), row.addr, $urandom, ret, 1'b0};
      end
      access_in = 1'b1;
      packet_in = req;
      @(negedge clk);                                        // Taken on the edge between
      access_in = 1'b0;
   endtask

   task automatic take_response(input logic [31:0] exp, input logic [30:0] ret,
                                input int unsigned hold);
      emesh_rsp_s held;
      while (!access_out) @(negedge clk);
      held = packet_out;
      check_val("packet_out.write", 32'(packet_out.write), 32'h1);
      check_val("packet_out.dst_addr", packet_out.dst_addr, {1'b0, ret});
      check_val("packet_out.data", packet_out.data, exp);
      repeat (hold) begin
         @(negedge clk);                                     // Stalled, nothing may move
         check_val("access_out", 32'(access_out), 32'h1);
         check_val("wait_out", 32'(wait_out), 32'h1);
         check_val("packet_out.dst_addr", packet_out.dst_addr, held.dst_addr);
         check_val("packet_out.data", packet_out.data, held.data);
      end
      wait_in = 1'b0;                                        // Release
      @(negedge clk);
      check_val("access_out", 32'(access_out), 32'h0);
   endtask

   //##########################################################################
   // Stimulus and result
   //##########################################################################

   initial begin : stimulus
      logic [30:0] ret;
      int unsigned hold;
      int unsigned errs_before;
      void'($urandom(65134));
      clk       = 1'b0;
      arst_n    = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      n_checks  = 0;
      n_errors  = 0;
      build_table();
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check_val("access_out", 32'(access_out), 32'h0);
      check_val("wait_out", 32'(wait_out), 32'h0);
      $display("reset: %s", (n_errors == 0) ? "ok      " : "mismatch");
      for (int i = 0; i < n_rows; i++) begin
         errs_before = n_errors;
         ret         = 31'($urandom);
         hold        = (!rows[i].wr && (i % 2 == 1)) ? $urandom_range(6, 2) : 0;
         wait_in     = (hold != 0);                          // Stall before data returns
         send_request(rows[i], ret);
         if (rows[i].wr) begin
            while (wait_out) @(negedge clk);                 // Done once bvalid seen
         end else begin
            take_response(rows[i].exp, ret, hold);
         end
         $display("row %2d %s addr 0x%h hold %0d: %s", i, rows[i].wr ? "write" : "read ",
                  rows[i].addr, hold, (n_errors == errs_before) ? "ok      " : "mismatch");
      end
      $display("%0d rows, %0d checks, %0d errors, assertion failure %0b",
               n_rows, n_checks, n_errors, accel_dut_i.props_i.prop_fail);
      if (n_errors == 0 && !accel_dut_i.props_i.prop_fail) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      #((n_rows * 20 + 50) * clk_period);
      $display("Watchdog expired, the table did not finish within %0d clock periods",
               n_rows * 20 + 50);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- compile.f
logic/emesh_pkg.sv
logic/axi_pkg.sv
logic/emesh_axi_master.sv
logic/accel_regs.sv
logic/accel_dut.sv
sim/accel_dut_props.sv
sim/accel_dut_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the accel_dut testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module accel_dut_tb -o accel_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/accel_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -q -x "TEST RESULT: PASS"; then
   exit 0
fi
exit 1
